//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

initial
begin
	clk = 1'b0;
	forever #10 clk = ~clk;	// 20 ns period
end

initial
begin
	rst_n = 1'b0;
	repeat (5) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;
end

endmodule

`default_nettype wire

//--- bench/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

localparam int N_INSTR = 14;	// instructions issued over all tests
localparam int CYCLE_LIMIT = N_INSTR * (2 * lc3b_pkg::DMEM_TIMEOUT + 8) + 20;

logic clk;
logic rst_n;
lc3b_pkg::ex_mem_t ex_mem;
logic load_ex_mem;
logic dmem_resp;
lc3b_pkg::lc3b_word dmem_rdata;
lc3b_pkg::dmem_req_t dmem_req;
logic mem_stall;
lc3b_pkg::lc3b_word mem_result;
logic mem_result_valid;
logic dmem_error;

lc3b_pkg::lc3b_word mem [0:255];
lc3b_pkg::dmem_req_t req_log[$];	// requests as they were answered
integer seed;
int lat_first;
int lat_second;
int acc_count;
int wait_cnt;
int req_seen;
logic silent;
int errors;
int checks;
int tests_run;
int cycle_cnt;

tb_clock_gen i_tb_clock_gen
(
	.clk(clk),
	.rst_n(rst_n)
);

mem_stage i_mem_stage
(
	.clk(clk),
	.rst_n(rst_n),
	.ex_mem(ex_mem),
	.load_ex_mem(load_ex_mem),
	.dmem_resp(dmem_resp),
	.dmem_rdata(dmem_rdata),
	.dmem_req(dmem_req),
	.mem_stall(mem_stall),
	.mem_result(mem_result),
	.mem_result_valid(mem_result_valid),
	.dmem_error(dmem_error)
);

// memory model, answers after lat_first or lat_second wait cycles
always @(negedge clk)
begin : responder
	logic [7:0] idx;
	int cur_lat;
	idx = dmem_req.adr[8:1];
	cur_lat = (acc_count == 0) ? lat_first : lat_second;
	if (dmem_req.cyc && dmem_req.stb)
	begin
		req_seen++;
		if (!silent && (wait_cnt == cur_lat))
		begin
			dmem_rdata <= mem[idx];
			if (dmem_req.we && dmem_req.sel[0])
				mem[idx][7:0] = dmem_req.wdata[7:0];
			if (dmem_req.we && dmem_req.sel[1])
				mem[idx][15:8] = dmem_req.wdata[15:8];
			req_log.push_back(dmem_req);
			dmem_resp <= 1'b1;
			wait_cnt = 0;
			acc_count++;
		end
		else
		begin
			dmem_resp <= 1'b0;
			wait_cnt++;
		end
	end
	else
	begin
		dmem_resp <= 1'b0;
		wait_cnt = 0;
	end
end

always @(posedge clk)
begin
	cycle_cnt++;
	if (cycle_cnt >= CYCLE_LIMIT)
	begin
		$display("run stopped after %0d cycles, an access never finished", cycle_cnt);
		$display("Test FAILED");
		$finish;
	end
end

task automatic check_word(input string name, input lc3b_pkg::lc3b_word exp,
	input lc3b_pkg::lc3b_word act);
	checks++;
	if (exp !== act)
	begin
		errors++;
		$display("FAILED %s: expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	checks++;
	if (exp !== act)
	begin
		errors++;
		$display("FAILED %s: expected %b actual %b", name, exp, act);
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	checks++;
	if (exp != act)
	begin
		errors++;
		$display("FAILED %s: expected %0d actual %0d", name, exp, act);
	end
endtask

function automatic string req_text(input lc3b_pkg::dmem_req_t r);
	return $sformatf("cyc=%b stb=%b we=%b sel=%b adr=%h wdata=%h",
		r.cyc, r.stb, r.we, r.sel, r.adr, r.wdata);
endfunction

task automatic check_req(input string name, input lc3b_pkg::dmem_req_t exp,
	input lc3b_pkg::dmem_req_t act);
	checks++;
	if (exp !== act)
	begin
		errors++;
		$display("FAILED %s: expected %s actual %s",
			name, req_text(exp), req_text(act));
	end
endtask

task automatic check_logged(input string name, input int idx, input lc3b_pkg::dmem_req_t exp);
	if (idx >= req_log.size())
	begin
		checks++;
		errors++;
		$display("%s: request %0d never reached the memory", name, idx);
	end
	else
		check_req(name, exp, req_log[idx]);
endtask

function automatic lc3b_pkg::dmem_req_t expected_req(input logic we,
	input lc3b_pkg::lc3b_mem_wmask sel, input lc3b_pkg::lc3b_word adr,
	input lc3b_pkg::lc3b_word wdata);
	lc3b_pkg::dmem_req_t r;
	r.cyc = 1'b1;
	r.stb = 1'b1;
	r.we = we;
	r.sel = sel;
	r.adr = adr;
	r.wdata = wdata;
	return r;
endfunction

// issues one instruction, counts stall cycles, samples the result cycle
task automatic run_instr(input lc3b_pkg::lc3b_opcode op, input lc3b_pkg::lc3b_word adr,
	input lc3b_pkg::lc3b_word data, input int l1, input int l2,
	output int stall_cycles, output logic vld, output lc3b_pkg::lc3b_word res);
	@(negedge clk);
	stall_cycles = 0;
	req_log.delete();
	acc_count = 0;
	lat_first = l1;
	lat_second = l2;
	ex_mem <= '{opcode: op, alu_out: adr, dest_out: data};
	load_ex_mem <= 1'b1;
	@(negedge clk);
	load_ex_mem <= 1'b0;
	@(posedge clk);
	while (mem_stall)
	begin
		stall_cycles++;
		@(posedge clk);
	end
	@(posedge clk);	// result registered one cycle after the final response
	vld = mem_result_valid;
	res = mem_result;
endtask

task automatic finish_test(input string name, input int base_err);
	tests_run++;
	$display("%-14s %0d errors", name, errors - base_err);
endtask

task automatic test_ldr_latency();
	int base_err;
	int stall;
	logic vld;
	lc3b_pkg::lc3b_word res;
	lc3b_pkg::lc3b_word exp;
	base_err = errors;
	exp = mem[8'h20];
	run_instr(lc3b_pkg::op_ldr, 16'h0040, 16'h0000, 0, 0, stall, vld, res);
	check_count("ldr_latency lat0 stall", 0, stall);
	check_flag("ldr_latency lat0 valid", 1'b1, vld);
	check_word("ldr_latency lat0 result", exp, res);
	check_logged("ldr_latency lat0 req", 0, expected_req(1'b0, 2'b11, 16'h0040, 16'h0000));
	exp = mem[8'h31];
	run_instr(lc3b_pkg::op_ldr, 16'h0062, 16'h1234, 3, 0, stall, vld, res);
	check_count("ldr_latency lat3 stall", 3, stall);
	check_flag("ldr_latency lat3 valid", 1'b1, vld);
	check_word("ldr_latency lat3 result", exp, res);
	check_count("ldr_latency lat3 requests", 1, req_log.size());
	finish_test("ldr_latency", base_err);
endtask

task automatic test_stores();
	int base_err;
	int stall;
	logic vld;
	lc3b_pkg::lc3b_word res;
	lc3b_pkg::lc3b_word old;
	base_err = errors;
	run_instr(lc3b_pkg::op_str, 16'h0010, 16'hbeef, 1, 0, stall, vld, res);
	check_count("stores str stall", 1, stall);
	check_flag("stores str valid", 1'b0, vld);
	check_logged("stores str req", 0, expected_req(1'b1, 2'b11, 16'h0010, 16'hbeef));
	check_word("stores str memory", 16'hbeef, mem[8'h08]);
	old = mem[8'h11];
	run_instr(lc3b_pkg::op_stb, 16'h0022, 16'h12a5, 0, 0, stall, vld, res);
	check_logged("stores stb even req", 0, expected_req(1'b1, 2'b01, 16'h0022, 16'ha5a5));
	check_word("stores stb even memory", {old[15:8], 8'ha5}, mem[8'h11]);
	old = mem[8'h12];
	run_instr(lc3b_pkg::op_stb, 16'h0025, 16'h343c, 2, 0, stall, vld, res);
	check_count("stores stb odd stall", 2, stall);
	check_logged("stores stb odd req", 0, expected_req(1'b1, 2'b10, 16'h0025, 16'h3c3c));
	check_word("stores stb odd memory", {8'h3c, old[7:0]}, mem[8'h12]);
	finish_test("stores", base_err);
endtask

task automatic test_ldb_sign();
	int base_err;
	int stall;
	logic vld;
	lc3b_pkg::lc3b_word res;
	base_err = errors;
	mem[8'h18] = 16'h7f85;
	mem[8'h19] = 16'h9c12;
	run_instr(lc3b_pkg::op_ldb, 16'h0030, 16'h0000, 1, 0, stall, vld, res);
	check_flag("ldb_sign even valid", 1'b1, vld);
	check_word("ldb_sign even result", 16'hff85, res);	// low byte 85
	run_instr(lc3b_pkg::op_ldb, 16'h0033, 16'h0000, 0, 0, stall, vld, res);
	check_flag("ldb_sign odd valid", 1'b1, vld);
	check_word("ldb_sign odd result", 16'hff9c, res);	// high byte 9c
	finish_test("ldb_sign", base_err);
endtask

task automatic test_indirect();
	int base_err;
	int stall;
	logic vld;
	lc3b_pkg::lc3b_word res;
	base_err = errors;
	mem[8'h28] = 16'h0086;	// pointer to word 43
	mem[8'h43] = 16'hc3d2;
	run_instr(lc3b_pkg::op_ldi, 16'h0050, 16'h0000, 2, 1, stall, vld, res);
	check_count("indirect ldi stall", 4, stall);
	check_flag("indirect ldi valid", 1'b1, vld);
	check_word("indirect ldi result", 16'hc3d2, res);
	check_logged("indirect ldi first req", 0, expected_req(1'b0, 2'b11, 16'h0050, 16'h0000));
	check_logged("indirect ldi second req", 1, expected_req(1'b0, 2'b11, 16'h0086, 16'h0000));
	mem[8'h30] = 16'h00a4;
	run_instr(lc3b_pkg::op_sti, 16'h0060, 16'h5a5a, 0, 2, stall, vld, res);
	check_count("indirect sti stall", 3, stall);
	check_flag("indirect sti valid", 1'b0, vld);
	check_logged("indirect sti first req", 0, expected_req(1'b0, 2'b11, 16'h0060, 16'h5a5a));
	check_logged("indirect sti second req", 1, expected_req(1'b1, 2'b11, 16'h00a4, 16'h5a5a));
	check_word("indirect sti memory", 16'h5a5a, mem[8'h52]);
	finish_test("indirect", base_err);
endtask

task automatic test_no_access();
	int base_err;
	int stall;
	int seen_before;
	logic vld;
	lc3b_pkg::lc3b_word res;
	base_err = errors;
	seen_before = req_seen;
	run_instr(lc3b_pkg::op_add, 16'h0040, 16'h0001, 0, 0, stall, vld, res);
	check_count("no_access add stall", 0, stall);
	run_instr(lc3b_pkg::op_br, 16'h0042, 16'h0000, 0, 0, stall, vld, res);
	check_count("no_access br stall", 0, stall);
	check_count("no_access cycles with a request", seen_before, req_seen);
	run_instr(lc3b_pkg::op_ldr, 16'h0044, 16'h0000, 1, 0, stall, vld, res);
	check_count("no_access ldr stall", 1, stall);
	seen_before = req_seen;
	repeat (4) @(posedge clk);	// opcode held, no new load_ex_mem
	check_count("no_access held ldr requests", seen_before, req_seen);
	check_flag("no_access held ldr stall", 1'b0, mem_stall);
	finish_test("no_access", base_err);
endtask

task automatic test_watchdog();
	int base_err;
	int stall;
	logic vld;
	lc3b_pkg::lc3b_word res;
	base_err = errors;
	silent = 1'b1;
	run_instr(lc3b_pkg::op_ldr, 16'h0070, 16'h0000, 0, 0, stall, vld, res);
	check_count("watchdog stall", lc3b_pkg::DMEM_TIMEOUT, stall);
	check_flag("watchdog valid", 1'b0, vld);
	check_flag("watchdog error set", 1'b1, dmem_error);
	silent = 1'b0;
	run_instr(lc3b_pkg::op_add, 16'h0000, 16'h0000, 0, 0, stall, vld, res);
	check_flag("watchdog error cleared", 1'b0, dmem_error);
	finish_test("watchdog", base_err);
endtask

initial
begin : main
	int i;
	seed = 32'h5518_ef76;
	for (i = 0; i < 256; i++)
		mem[i] = 16'($random(seed));
	ex_mem <= '0;
	load_ex_mem <= 1'b0;
	dmem_resp <= 1'b0;
	dmem_rdata <= '0;
	silent = 1'b0;
	lat_first = 0;
	lat_second = 0;
	acc_count = 0;
	wait_cnt = 0;
	req_seen = 0;
	errors = 0;
	checks = 0;
	tests_run = 0;
	cycle_cnt = 0;
	@(posedge rst_n);
	test_ldr_latency();
	test_stores();
	test_ldb_sign();
	test_indirect();
	test_no_access();
	test_watchdog();
	$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
	if (errors == 0)
		$display("Test OK");
	else
		$display("Test FAILED");
	$finish;
end

endmodule

`default_nettype wire

//--- flist.f
hw/lc3b_pkg.sv
hw/mem_access_fsm.sv
hw/dmem_wait_timer.sv
hw/dmem_addr_path.sv
hw/load_align.sv
hw/mem_stage.sv
bench/tb_clock_gen.sv
bench/tb_mem_stage.sv

//--- hw/dmem_addr_path.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_addr_path
(
	input wire clk,
	input wire rst_n,
	input wire lc3b_pkg::ex_mem_t ex_mem,
	input wire lc3b_pkg::mem_phase_e phase,
	input wire dmem_resp,
	input wire lc3b_pkg::lc3b_word dmem_rdata,
	input wire cyc,
	input wire stb,
	input wire we,

	output lc3b_pkg::dmem_req_t dmem_req
);

lc3b_pkg::lc3b_word ptr_q;	// pointer word from the first ldi/sti access
logic ptr_load;

assign ptr_load = stb && dmem_resp && (phase == lc3b_pkg::ph_first)
	&& lc3b_pkg::is_indirect(ex_mem.opcode);

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		ptr_q <= '0;
	else if (ptr_load)
		ptr_q <= dmem_rdata;
end

always_comb
begin
	dmem_req.cyc = cyc;
	dmem_req.stb = stb;
	dmem_req.we = we;

	if (phase == lc3b_pkg::ph_second)
		dmem_req.adr = ptr_q;
	else
		dmem_req.adr = ex_mem.alu_out;

	if (ex_mem.opcode == lc3b_pkg::op_stb)
	begin
		// byte store goes out on both lanes, sel picks the one written
		dmem_req.sel = dmem_req.adr[0] ? 2'b10 : 2'b01;
		dmem_req.wdata = {ex_mem.dest_out[7:0], ex_mem.dest_out[7:0]};
	end
	else
	begin
		dmem_req.sel = 2'b11;
		dmem_req.wdata = ex_mem.dest_out;
	end
end

endmodule

`default_nettype wire

//--- hw/dmem_wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_wait_timer
(
	input wire clk,
	input wire rst_n,
	input wire stb,
	input wire dmem_resp,

	output logic timeout
);

localparam logic [lc3b_pkg::DMEM_TIMER_W-1:0] LAST_WAIT =
	lc3b_pkg::DMEM_TIMER_W'(lc3b_pkg::DMEM_TIMEOUT - 1);

logic [lc3b_pkg::DMEM_TIMER_W-1:0] wait_cnt;	// completed unanswered cycles
logic waiting;

assign waiting = stb && !dmem_resp;
assign timeout = waiting && (wait_cnt == LAST_WAIT);

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		wait_cnt <= '0;
	else if (!waiting || timeout)
		wait_cnt <= '0;
	else
		wait_cnt <= wait_cnt + 1'b1;
end

// a timeout needs the whole run of unanswered request cycles behind it
a_timeout_at_limit: assert property (
	@(posedge clk) disable iff (!rst_n)
	timeout |-> $past(waiting, lc3b_pkg::DMEM_TIMEOUT - 1)
) else $error("watchdog fired before the wait limit");

endmodule

`default_nettype wire

//--- hw/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [1:0] lc3b_mem_wmask;	// bit 0 is the low byte lane

	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// EX/MEM latch contents seen by the memory stage
	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_word alu_out;	// effective address
		lc3b_word dest_out;	// store data
	} ex_mem_t;

	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		lc3b_mem_wmask sel;
		lc3b_word adr;
		lc3b_word wdata;
	} dmem_req_t;

	typedef enum logic [1:0]
	{
		ph_first,	// first or only access pending
		ph_second,	// pointed-to access of ldi/sti pending
		ph_done
	} mem_phase_e;

	localparam int DMEM_TIMEOUT = 16;	// request cycles allowed before abandoning
	localparam int DMEM_TIMER_W = $clog2(DMEM_TIMEOUT);

	function automatic logic is_mem_op(lc3b_opcode op);
		return op inside {op_ldr, op_ldb, op_ldi, op_str, op_stb, op_sti};
	endfunction

	function automatic logic is_load(lc3b_opcode op);
		return op inside {op_ldr, op_ldb, op_ldi};
	endfunction

	function automatic logic is_indirect(lc3b_opcode op);
		return op inside {op_ldi, op_sti};
	endfunction

endpackage

`default_nettype wire

//--- hw/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align
(
	input wire clk,
	input wire rst_n,
	input wire lc3b_pkg::lc3b_opcode opcode,
	input wire lc3b_pkg::mem_phase_e phase,
	input wire adr_lsb,
	input wire dmem_resp,
	input wire lc3b_pkg::lc3b_word dmem_rdata,

	output lc3b_pkg::lc3b_word mem_result,
	output logic mem_result_valid
);

logic final_resp;
logic [7:0] rd_byte;

always_comb
begin
	final_resp = 1'b0;
	if (dmem_resp && lc3b_pkg::is_load(opcode))
	begin
		if (phase == lc3b_pkg::ph_second)
			final_resp = 1'b1;
		else if ((phase == lc3b_pkg::ph_first) && !lc3b_pkg::is_indirect(opcode))
			final_resp = 1'b1;
	end

	rd_byte = adr_lsb ? dmem_rdata[15:8] : dmem_rdata[7:0];	// odd address takes high byte
end

always_ff @(posedge clk)
begin
	if (final_resp)
	begin
		if (opcode == lc3b_pkg::op_ldb)
			mem_result <= {{8{rd_byte[7]}}, rd_byte};
		else
			mem_result <= dmem_rdata;
	end
end

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		mem_result_valid <= 1'b0;
	else
		mem_result_valid <= final_resp;
end

endmodule

`default_nettype wire

//--- hw/mem_access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_fsm
(
	input wire clk,
	input wire rst_n,
	input wire lc3b_pkg::lc3b_opcode opcode,
	input wire load_ex_mem,
	input wire dmem_resp,
	input wire timeout,

	output lc3b_pkg::mem_phase_e phase,
	output logic cyc,
	output logic stb,
	output logic we,
	output logic mem_stall,
	output logic dmem_error
);

logic mem_op;
logic direct_store;
logic indirect_op;
logic active;
logic last_access;

always_comb
begin
	mem_op = lc3b_pkg::is_mem_op(opcode);
	indirect_op = lc3b_pkg::is_indirect(opcode);
	direct_store = (opcode == lc3b_pkg::op_str) || (opcode == lc3b_pkg::op_stb);
	active = mem_op && (phase != lc3b_pkg::ph_done);

	// the pointer read of ldi/sti is never the last access
	last_access = !(indirect_op && (phase == lc3b_pkg::ph_first));
end

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
	begin
		phase <= lc3b_pkg::ph_done;
	end
	else if (load_ex_mem)
	begin
		phase <= lc3b_pkg::ph_first;	// new instruction wins over a response
	end
	else if (timeout)
	begin
		phase <= lc3b_pkg::ph_done;
	end
	else if (active && dmem_resp)
	begin
		if (last_access)
			phase <= lc3b_pkg::ph_done;
		else
			phase <= lc3b_pkg::ph_second;
	end
end

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
	begin
		dmem_error <= 1'b0;
	end
	else if (load_ex_mem)
	begin
		dmem_error <= 1'b0;
	end
	else if (timeout)
	begin
		dmem_error <= 1'b1;	// sticky until the next instruction
	end
end

always_comb
begin
	cyc = active;
	stb = active;
	we = 1'b0;
	if (active)
	begin
		if (direct_store)
			we = 1'b1;
		else if ((opcode == lc3b_pkg::op_sti) && (phase == lc3b_pkg::ph_second))
			we = 1'b1;
	end

	// stall drops in the response cycle of the final access only
	mem_stall = active && !(dmem_resp && last_access);
end

a_resp_needs_req: assert property (
	@(posedge clk) disable iff (!rst_n)
	dmem_resp |-> stb
) else $error("memory response without an outstanding request");

a_second_is_indirect: assert property (
	@(posedge clk) disable iff (!rst_n)
	(phase == lc3b_pkg::ph_second) |-> indirect_op
) else $error("second access phase for a non-indirect opcode");

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
(
	input wire clk,
	input wire rst_n,
	input wire lc3b_pkg::ex_mem_t ex_mem,
	input wire load_ex_mem,
	input wire dmem_resp,
	input wire lc3b_pkg::lc3b_word dmem_rdata,

	output lc3b_pkg::dmem_req_t dmem_req,
	output logic mem_stall,
	output lc3b_pkg::lc3b_word mem_result,
	output logic mem_result_valid,
	output logic dmem_error
);

lc3b_pkg::mem_phase_e phase;
logic cyc;
logic stb;
logic we;
logic timeout;

mem_access_fsm i_mem_access_fsm
(
	.clk(clk),
	.rst_n(rst_n),
	.opcode(ex_mem.opcode),
	.load_ex_mem(load_ex_mem),
	.dmem_resp(dmem_resp),
	.timeout(timeout),
	.phase(phase),
	.cyc(cyc),
	.stb(stb),
	.we(we),
	.mem_stall(mem_stall),
	.dmem_error(dmem_error)
);

dmem_wait_timer i_dmem_wait_timer
(
	.clk(clk),
	.rst_n(rst_n),
	.stb(stb),
	.dmem_resp(dmem_resp),
	.timeout(timeout)
);

dmem_addr_path i_dmem_addr_path
(
	.clk(clk),
	.rst_n(rst_n),
	.ex_mem(ex_mem),
	.phase(phase),
	.dmem_resp(dmem_resp),
	.dmem_rdata(dmem_rdata),
	.cyc(cyc),
	.stb(stb),
	.we(we),
	.dmem_req(dmem_req)
);

load_align i_load_align
(
	.clk(clk),
	.rst_n(rst_n),
	.opcode(ex_mem.opcode),
	.phase(phase),
	.adr_lsb(dmem_req.adr[0]),	// byte select follows the address on the bus
	.dmem_resp(dmem_resp),
	.dmem_rdata(dmem_rdata),
	.mem_result(mem_result),
	.mem_result_valid(mem_result_valid)
);

endmodule

`default_nettype wire
